/* common/periph_config.svh */
`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// register map, byte addresses
`define PERIPH_SWITCH_ADDR    16'h0000
`define PERIPH_KEYPAD_ADDR    16'h0004
`define PERIPH_BICOLOR0_ADDR  16'h0008
`define PERIPH_BICOLOR1_ADDR  16'h000c
`define PERIPH_LED_ADDR       16'h0010
`define PERIPH_NUM_ADDR       16'h0014
`define PERIPH_TIMER_ADDR     16'h0018

// reset values
`define PERIPH_LED_RESET      16'hffff
`define PERIPH_NUM_RESET      32'h0000_0000

// clock cycles each display digit stays lit
`define PERIPH_SEG_DIV        8

`endif

/* common/periph_pkg.sv */
`default_nettype none

package periph_pkg;

    // one data word on the register bus
    typedef logic [31:0] bus_word_t;

    // bicolor led drive state
    typedef enum logic [1:0] {
        BICOLOR_OFF   = 2'd0,
        BICOLOR_RED   = 2'd1,
        BICOLOR_GREEN = 2'd2,
        BICOLOR_BOTH  = 2'd3
    } bicolor_t;

    typedef logic [3:0] hex_digit_t;

    // display word, bus view and per-digit view
    // digit[0] is the least significant nibble
    typedef union packed {
        bus_word_t            word;
        hex_digit_t [7:0]     digit;
    } num_word_t;

endpackage

`default_nettype wire

/* gpio/gpio_timer.sv */
`timescale 1ns/10ps
`default_nettype none

module gpio_timer (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        load,
    input  wire periph_pkg::bus_word_t value,
    output periph_pkg::bus_word_t      count
);

    periph_pkg::bus_word_t count_next;

    // free running, wraps at 2^32
    always_comb begin
        if (load) begin
            count_next = value;
        end else begin
            count_next = count + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            count <= '0;
        end else begin
            count <= count_next;
        end
    end

endmodule

`default_nettype wire

/* gpio/gpio_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "periph_config.svh"

module gpio_regs (
    input  wire                   clk,
    input  wire                   rst,
    // register bus
    input  wire                   en,
    input  wire                   write_en,
    input  wire [15:0]            addr,
    input  wire periph_pkg::bus_word_t data_in,
    output periph_pkg::bus_word_t data_out,
    // board inputs
    input  wire [7:0]             switch,
    input  wire [15:0]            keypad,
    // board outputs
    output periph_pkg::bicolor_t  bicolor_led_0,
    output periph_pkg::bicolor_t  bicolor_led_1,
    output logic [15:0]           led,
    output periph_pkg::num_word_t num,
    // timer side
    input  wire periph_pkg::bus_word_t timer_count,
    output logic                  timer_load,
    output periph_pkg::bus_word_t timer_value
);

    wire rd_sel = en && !write_en;
    wire wr_sel = en && write_en;

    // timer write seen last cycle, blocks reload while held
    logic timer_wr_q;

    wire timer_wr = wr_sel && (addr == `PERIPH_TIMER_ADDR);

    always_ff @(posedge clk) begin
        if (!rst) begin
            timer_wr_q <= 1'b0;
        end else begin
            timer_wr_q <= timer_wr;
        end
    end

    // load only on the first cycle of a run
    assign timer_load  = timer_wr && !timer_wr_q;
    assign timer_value = data_in;

    // read data, registered, held between reads
    always_ff @(posedge clk) begin
        if (!rst) begin
            data_out <= '0;
        end else if (rd_sel) begin
            case (addr)
                `PERIPH_SWITCH_ADDR:   data_out <= {24'h0, switch};
                `PERIPH_KEYPAD_ADDR:   data_out <= {16'h0, keypad};
                `PERIPH_BICOLOR0_ADDR: data_out <= {30'h0, bicolor_led_0};
                `PERIPH_BICOLOR1_ADDR: data_out <= {30'h0, bicolor_led_1};
                `PERIPH_LED_ADDR:      data_out <= {16'h0, led};
                `PERIPH_NUM_ADDR:      data_out <= num.word;
                `PERIPH_TIMER_ADDR:    data_out <= timer_count;
                default: ;
            endcase
        end
    end

    // writable output registers
    always_ff @(posedge clk) begin
        if (!rst) begin
            bicolor_led_0 <= periph_pkg::BICOLOR_OFF;
            bicolor_led_1 <= periph_pkg::BICOLOR_OFF;
            led           <= `PERIPH_LED_RESET;
            num.word      <= `PERIPH_NUM_RESET;
        end else if (wr_sel) begin
            case (addr)
                `PERIPH_BICOLOR0_ADDR: begin
                    bicolor_led_0 <= periph_pkg::bicolor_t'(data_in[1:0]);
                end
                `PERIPH_BICOLOR1_ADDR: begin
                    bicolor_led_1 <= periph_pkg::bicolor_t'(data_in[1:0]);
                end
                `PERIPH_LED_ADDR: begin
                    led <= data_in[15:0];
                end
                `PERIPH_NUM_ADDR: begin
                    num.word <= data_in;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/seg_scan.sv */
`timescale 1ns/10ps
`default_nettype none

`include "periph_config.svh"

module seg_scan #(
    parameter int scan_div = `PERIPH_SEG_DIV
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire periph_pkg::num_word_t num,
    output logic [7:0]                 seg_an,
    output logic [6:0]                 seg_cat
);

    localparam int div_w = (scan_div > 1) ? $clog2(scan_div) : 1;

    logic [div_w-1:0] div_cnt;
    logic [2:0]       digit_idx;

    // active low segments, bit order g..a
    function automatic logic [6:0] hex_to_seg(input periph_pkg::hex_digit_t d);
        logic [6:0] on;
        case (d)
            4'h0: on = 7'h3f;
            4'h1: on = 7'h06;
            4'h2: on = 7'h5b;
            4'h3: on = 7'h4f;
            4'h4: on = 7'h66;
            4'h5: on = 7'h6d;
            4'h6: on = 7'h7d;
            4'h7: on = 7'h07;
            4'h8: on = 7'h7f;
            4'h9: on = 7'h6f;
            4'ha: on = 7'h77;
            4'hb: on = 7'h7c;
            4'hc: on = 7'h39;
            4'hd: on = 7'h5e;
            4'he: on = 7'h79;
            default: on = 7'h71;
        endcase
        return ~on;
    endfunction

    // digit index steps every scan_div cycles
    always_ff @(posedge clk) begin
        if (!rst) begin
            div_cnt   <= '0;
            digit_idx <= 3'd0;
        end else if (div_cnt == div_w'(scan_div - 1)) begin
            div_cnt   <= '0;
            digit_idx <= digit_idx + 3'd1;
        end else begin
            div_cnt <= div_cnt + div_w'(1);
        end
    end

    // anode and cathode loaded on the same edge
    always_ff @(posedge clk) begin
        if (!rst) begin
            seg_an  <= 8'hff;
            seg_cat <= 7'h7f;
        end else begin
            seg_an  <= ~(8'h01 << digit_idx);
            seg_cat <= hex_to_seg(num.digit[digit_idx]);
        end
    end

endmodule

`default_nettype wire

/* verilog/periph_top.sv */
`timescale 1ns/10ps
`default_nettype none

module periph_top (
    input  wire                        clk,
    input  wire                        rst,
    // register bus
    input  wire                        en,
    input  wire                        write_en,
    input  wire [15:0]                 addr,
    input  wire periph_pkg::bus_word_t data_in,
    output wire periph_pkg::bus_word_t data_out,
    // board io
    input  wire [7:0]                  switch,
    input  wire [15:0]                 keypad,
    output wire periph_pkg::bicolor_t  bicolor_led_0,
    output wire periph_pkg::bicolor_t  bicolor_led_1,
    output wire [15:0]                 led,
    output wire [7:0]                  seg_an,
    output wire [6:0]                  seg_cat
);

    wire                        timer_load;
    wire periph_pkg::bus_word_t timer_value;
    wire periph_pkg::bus_word_t timer_count;
    wire periph_pkg::num_word_t num;

    gpio_regs u_regs (
        .clk           (clk),
        .rst           (rst),
        .en            (en),
        .write_en      (write_en),
        .addr          (addr),
        .data_in       (data_in),
        .data_out      (data_out),
        .switch        (switch),
        .keypad        (keypad),
        .bicolor_led_0 (bicolor_led_0),
        .bicolor_led_1 (bicolor_led_1),
        .led           (led),
        .num           (num),
        .timer_count   (timer_count),
        .timer_load    (timer_load),
        .timer_value   (timer_value)
    );

    gpio_timer u_timer (
        .clk   (clk),
        .rst   (rst),
        .load  (timer_load),
        .value (timer_value),
        .count (timer_count)
    );

    // scan rate from the config default
    seg_scan u_scan (
        .clk     (clk),
        .rst     (rst),
        .num     (num),
        .seg_an  (seg_an),
        .seg_cat (seg_cat)
    );

endmodule

`default_nettype wire

/* tests/periph_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

`include "periph_config.svh"

module periph_asserts (
    input wire                        clk,
    input wire                        rst,
    input wire                        en,
    input wire                        write_en,
    input wire [7:0]                  seg_an,
    input wire periph_pkg::bus_word_t data_out,
    input wire [15:0]                 led
);

    // one digit lit once the scanner has run a cycle
    assert property (@(posedge clk) $past(rst) |-> $onehot(~seg_an))
        else $error("seg_an is not one-hot low after reset");

    // read data only moves after a read
    assert property (@(posedge clk)
        $past(rst) && !$past(en && !write_en) |-> $stable(data_out))
        else $error("data_out changed without a read");

    assert property (@(posedge clk) !$past(rst) && rst |-> led == `PERIPH_LED_RESET)
        else $error("led is not all ones after reset");

endmodule

bind periph_top periph_asserts u_asserts (
    .clk      (clk),
    .rst      (rst),
    .en       (en),
    .write_en (write_en),
    .seg_an   (seg_an),
    .data_out (data_out),
    .led      (led)
);

`default_nettype wire

/* tests/tb_periph.sv */
`timescale 1ns/10ps
`default_nettype none

`include "periph_config.svh"

module tb_periph;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_CYCLES   = 3000;
    localparam int WATCHDOG_NS  = (NUM_CYCLES + 50) * CLK_PERIOD;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  en;
    logic                  write_en;
    logic [15:0]           addr;
    periph_pkg::bus_word_t data_in;
    logic [7:0]            switch;
    logic [15:0]           keypad;

    wire periph_pkg::bus_word_t data_out;
    wire periph_pkg::bicolor_t  bicolor_led_0;
    wire periph_pkg::bicolor_t  bicolor_led_1;
    wire [15:0]                 led;
    wire [7:0]                  seg_an;
    wire [6:0]                  seg_cat;

    // reference model state
    periph_pkg::bus_word_t m_data_out;
    periph_pkg::bicolor_t  m_bic0;
    periph_pkg::bicolor_t  m_bic1;
    logic [15:0]           m_led;
    periph_pkg::bus_word_t m_num;
    periph_pkg::bus_word_t m_count;
    logic                  m_timer_wr_q;
    int                    m_div;
    int                    m_idx;
    logic [7:0]            m_an;
    logic [6:0]            m_cat;

    logic [31:0] lfsr_state = 32'h6a21_39ca;
    int          hold_left  = 0;

    periph_top dut (
        .clk           (clk),
        .rst           (rst),
        .en            (en),
        .write_en      (write_en),
        .addr          (addr),
        .data_in       (data_in),
        .data_out      (data_out),
        .switch        (switch),
        .keypad        (keypad),
        .bicolor_led_0 (bicolor_led_0),
        .bicolor_led_1 (bicolor_led_1),
        .led           (led),
        .seg_an        (seg_an),
        .seg_cat       (seg_cat)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic periph_pkg::bus_word_t take_bits(input int n);
        periph_pkg::bus_word_t bits;
        logic fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // lit segments, bit order g..a
    function automatic logic [6:0] seven_seg_code(input periph_pkg::hex_digit_t d);
        case (d)
            4'h0: return 7'b0111111;
            4'h1: return 7'b0000110;
            4'h2: return 7'b1011011;
            4'h3: return 7'b1001111;
            4'h4: return 7'b1100110;
            4'h5: return 7'b1101101;
            4'h6: return 7'b1111101;
            4'h7: return 7'b0000111;
            4'h8: return 7'b1111111;
            4'h9: return 7'b1101111;
            4'ha: return 7'b1110111;
            4'hb: return 7'b1111100;
            4'hc: return 7'b0111001;
            4'hd: return 7'b1011110;
            4'he: return 7'b1111001;
            default: return 7'b1110001;
        endcase
    endfunction

    task automatic stop_on_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_word(input string name, input periph_pkg::bus_word_t exp,
                              input periph_pkg::bus_word_t act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_bicolor(input string name, input periph_pkg::bicolor_t exp,
                                 input periph_pkg::bicolor_t act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_led(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_seg(input logic [7:0] exp_an, input logic [6:0] exp_cat,
                             input logic [7:0] act_an, input logic [6:0] act_cat);
        if (act_an !== exp_an || act_cat !== exp_cat) begin
            $display("Error at %0t: seg_an/seg_cat expected %h/%h, got %h/%h",
                     $time, exp_an, exp_cat, act_an, act_cat);
            stop_on_failure();
        end
    endtask

    task automatic model_reset();
        m_data_out   = '0;
        m_bic0       = periph_pkg::BICOLOR_OFF;
        m_bic1       = periph_pkg::BICOLOR_OFF;
        m_led        = `PERIPH_LED_RESET;
        m_num        = '0;
        m_count      = '0;
        m_timer_wr_q = 1'b0;
        m_div        = 0;
        m_idx        = 0;
        m_an         = 8'hff;
        m_cat        = 7'h7f;
    endtask

    // one clock edge of the reference model, using the inputs seen at that edge
    task automatic model_step();
        logic                  rd;
        logic                  wr;
        logic                  t_wr;
        periph_pkg::bus_word_t next_count;
        if (!rst) begin
            model_reset();
        end else begin
            rd   = en && !write_en;
            wr   = en && write_en;
            t_wr = wr && (addr == `PERIPH_TIMER_ADDR);
            if (rd) begin
                case (addr)
                    `PERIPH_SWITCH_ADDR:   m_data_out = {24'h0, switch};
                    `PERIPH_KEYPAD_ADDR:   m_data_out = {16'h0, keypad};
                    `PERIPH_BICOLOR0_ADDR: m_data_out = {30'h0, m_bic0};
                    `PERIPH_BICOLOR1_ADDR: m_data_out = {30'h0, m_bic1};
                    `PERIPH_LED_ADDR:      m_data_out = {16'h0, m_led};
                    `PERIPH_NUM_ADDR:      m_data_out = m_num;
                    `PERIPH_TIMER_ADDR:    m_data_out = m_count;
                    default: ;
                endcase
            end
            // display sees last cycle's num
            m_an  = ~(8'h01 << m_idx);
            m_cat = ~seven_seg_code(m_num[m_idx * 4 +: 4]);
            if (t_wr && !m_timer_wr_q) begin
                next_count = data_in;
            end else begin
                next_count = m_count + 32'd1;
            end
            m_timer_wr_q = t_wr;
            if (wr) begin
                case (addr)
                    `PERIPH_BICOLOR0_ADDR: m_bic0 = periph_pkg::bicolor_t'(data_in[1:0]);
                    `PERIPH_BICOLOR1_ADDR: m_bic1 = periph_pkg::bicolor_t'(data_in[1:0]);
                    `PERIPH_LED_ADDR:      m_led = data_in[15:0];
                    `PERIPH_NUM_ADDR:      m_num = data_in;
                    default: ;
                endcase
            end
            m_count = next_count;
            if (m_div == `PERIPH_SEG_DIV - 1) begin
                m_div = 0;
                m_idx = (m_idx + 1) % 8;
            end else begin
                m_div = m_div + 1;
            end
        end
    endtask

    task automatic drive_inputs(input int cyc);
        periph_pkg::bus_word_t r;
        logic [2:0]            idx;
        r = take_bits(1);
        if (r[0]) begin
            r = take_bits(8);
            switch <= r[7:0];
        end
        r = take_bits(1);
        if (r[0]) begin
            r = take_bits(16);
            keypad <= r[15:0];
        end
        r = take_bits(32);
        data_in <= r;
        if (cyc < RESET_CYCLES - 1) begin
            en       <= 1'b0;
            write_en <= 1'b0;
        end else if (cyc < RESET_CYCLES + 6) begin
            // read back every mapped register once after reset
            idx = 3'(cyc - RESET_CYCLES + 1);
            en       <= 1'b1;
            write_en <= 1'b0;
            addr     <= {11'h0, idx, 2'b00};
        end else if (hold_left > 0) begin
            hold_left = hold_left - 1;
            en        <= 1'b1;
            write_en  <= 1'b1;
            addr      <= `PERIPH_TIMER_ADDR;
        end else begin
            r   = take_bits(5);
            idx = r[4:2];
            case (r[1:0])
                2'd0: begin
                    en       <= 1'b0;
                    write_en <= idx[0];
                end
                2'd1: begin
                    en       <= 1'b1;
                    write_en <= 1'b0;
                    addr     <= {11'h0, idx, 2'b00};
                end
                2'd2: begin
                    en       <= 1'b1;
                    write_en <= 1'b1;
                    addr     <= {11'h0, idx, 2'b00};
                end
                default: begin
                    hold_left = int'(idx) + 1;
                    en        <= 1'b1;
                    write_en  <= 1'b1;
                    addr      <= `PERIPH_TIMER_ADDR;
                end
            endcase
        end
        if (cyc == RESET_CYCLES - 1) begin
            rst <= 1'b1;
        end
    endtask

    initial begin
        rst      <= 1'b0;
        en       <= 1'b0;
        write_en <= 1'b0;
        addr     <= '0;
        data_in  <= '0;
        switch   <= '0;
        keypad   <= '0;
        model_reset();
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(posedge clk);
            model_step();
            drive_inputs(cyc);
            @(negedge clk);
            check_word("data_out", m_data_out, data_out);
            check_bicolor("bicolor_led_0", m_bic0, bicolor_led_0);
            check_bicolor("bicolor_led_1", m_bic1, bicolor_led_1);
            check_led("led", m_led, led);
            check_seg(m_an, m_cat, seg_an, seg_cat);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the test loop did not reach its end in time");
        stop_on_failure();
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+common
common/periph_pkg.sv
gpio/gpio_timer.sv
gpio/gpio_regs.sv
verilog/seg_scan.sv
verilog/periph_top.sv
tests/periph_asserts.sv
tests/tb_periph.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the peripheral testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f flist.f --top-module tb_periph -o sim_periph

# the log decides the result, so a non-zero exit here is not fatal yet
./obj_dir/sim_periph > sim.log 2>&1 || true
cat sim.log

if grep -q -F '*** TEST FAILED ***' sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q -F '*** TEST PASSED ***' sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation finished cleanly"
